/* src/match_pkg.sv */
/*
 * Shared game types for the light-cycle match control:
 * state, outcome and winner encodings, score and status structs,
 * AXI4-Lite request/response structs and the register map.
 */
`default_nettype none

package match_pkg;

	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		COUNTDOWN  = 3'd1,
		PLAY       = 3'd2,
		ROUND_OVER = 3'd3,
		MATCH_OVER = 3'd4
	} game_state_e;

	// result of one frame's crash check
	typedef enum logic [1:0] {
		NONE       = 2'd0,
		RED_CRASH  = 2'd1,
		BLUE_CRASH = 2'd2,
		DRAW       = 2'd3
	} outcome_e;

	typedef enum logic [1:0] {
		NO_WINNER = 2'd0,
		RED_WINS  = 2'd1,
		BLUE_WINS = 2'd2
	} winner_e;

	typedef logic [3:0] score_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] blue;
	} head_colors_t;

	// blue in the upper nibble, same layout as the SCORE register
	typedef struct packed {
		score_t blue;
		score_t red;
	} score_pair_t;

	typedef struct packed {
		game_state_e state;
		winner_e     winner;
		score_pair_t scores;
		logic [7:0]  rounds;
	} match_status_t;

	typedef struct packed {
		logic [3:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [3:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	localparam logic [7:0] BACKGROUND_COLOR = 8'h01;
	localparam logic [1:0] AXI_RESP_OKAY    = 2'b00;

	// register offsets
	localparam logic [3:0] REG_CTRL   = 4'h0;
	localparam logic [3:0] REG_STATUS = 4'h4;
	localparam logic [3:0] REG_SCORE  = 4'h8;
	localparam logic [3:0] REG_ROUNDS = 4'hC;

endpackage

`default_nettype wire

/* src/round_fsm.sv */
/*
 * Match and round state machine.
 * Sequences idle, countdown, play, a one-cycle round-over and
 * match-over; drives countdown_run, match_clear and round_reset.
 */
`timescale 1ns/1ps
`default_nettype none

module round_fsm (
	input  wire logic                   Clk,
	input  wire logic                   rst_n,
	input  wire logic                   start_cmd,
	input  wire logic                   abort_cmd,
	input  wire logic                   countdown_done,
	input  wire match_pkg::outcome_e    outcome,
	input  wire match_pkg::winner_e     winner,
	output match_pkg::game_state_e      state,
	output logic                        countdown_run,
	output logic                        match_clear,
	output logic                        round_reset
);

	match_pkg::game_state_e state_next;
	logic                   clear_next;

	always_comb
	begin
		state_next = state;
		clear_next = 1'b0;
		if (abort_cmd)
		begin
			// abort from anywhere, scores wiped too
			state_next = match_pkg::IDLE;
			clear_next = 1'b1;
		end
		else
		begin
			case (state)
				match_pkg::IDLE, match_pkg::MATCH_OVER:
				begin
					if (start_cmd)
					begin
						state_next = match_pkg::COUNTDOWN;
						clear_next = 1'b1;
					end
				end
				match_pkg::COUNTDOWN:
				begin
					if (countdown_done)
						state_next = match_pkg::PLAY;
				end
				match_pkg::PLAY:
				begin
					if (outcome != match_pkg::NONE)
						state_next = match_pkg::ROUND_OVER;
				end
				match_pkg::ROUND_OVER:
				begin
					// winner already reflects this round's credit
					if (winner != match_pkg::NO_WINNER)
						state_next = match_pkg::MATCH_OVER;
					else
						state_next = match_pkg::COUNTDOWN;
				end
				default:
					state_next = match_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			state       <= match_pkg::IDLE;
			match_clear <= 1'b0;
		end
		else
		begin
			state       <= state_next;
			match_clear <= clear_next;
		end
	end

	assign countdown_run = (state == match_pkg::COUNTDOWN);
	// one cycle per round, also tells the renderer to redraw
	assign round_reset   = (state == match_pkg::ROUND_OVER);

endmodule

`default_nettype wire

/* src/frame_timer.sv */
/*
 * Frame tick divider and countdown frame counter.
 */
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
	parameter int FRAME_DIV        = 16,
	parameter int COUNTDOWN_FRAMES = 3
) (
	input  wire logic Clk,
	input  wire logic rst_n,
	input  wire logic countdown_run,
	output logic      frame_tick,
	output logic      countdown_done
);

	localparam int DIV_W = $clog2(FRAME_DIV + 1);
	localparam int CD_W  = $clog2(COUNTDOWN_FRAMES + 1);

	logic [DIV_W-1:0] div_cnt;
	logic [CD_W-1:0]  cd_cnt;

	// free running divider, tick on the last count
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			div_cnt    <= '0;
			frame_tick <= 1'b0;
		end
		else
		begin
			frame_tick <= (div_cnt == DIV_W'(FRAME_DIV - 1));
			if (div_cnt == DIV_W'(FRAME_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	// ticks seen so far in this countdown
	always_ff @(posedge Clk)
	begin
		if (!rst_n || !countdown_run || countdown_done)
			cd_cnt <= '0;
		else if (frame_tick)
			cd_cnt <= cd_cnt + 1'b1;
	end

	assign countdown_done = countdown_run && frame_tick &&
		(cd_cnt == CD_W'(COUNTDOWN_FRAMES - 1));

endmodule

`default_nettype wire

/* src/crash_detect.sv */
/*
 * Crash detection.
 * Compares both head colours against the background once per
 * frame during play and registers a single outcome.
 */
`timescale 1ns/1ps
`default_nettype none

module crash_detect (
	input  wire logic                    Clk,
	input  wire logic                    rst_n,
	input  wire logic                    frame_tick,
	input  wire match_pkg::game_state_e  state,
	input  wire match_pkg::head_colors_t head_colors,
	output match_pkg::outcome_e          outcome
);

	logic                red_hit;
	logic                blue_hit;
	match_pkg::outcome_e sample;

	assign red_hit  = (head_colors.red  != match_pkg::BACKGROUND_COLOR);
	assign blue_hit = (head_colors.blue != match_pkg::BACKGROUND_COLOR);

	// both at once counts as a draw, never two points
	always_comb
	begin
		if (red_hit && blue_hit)
			sample = match_pkg::DRAW;
		else if (red_hit)
			sample = match_pkg::RED_CRASH;
		else if (blue_hit)
			sample = match_pkg::BLUE_CRASH;
		else
			sample = match_pkg::NONE;
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			outcome <= match_pkg::NONE;
		else if (frame_tick && state == match_pkg::PLAY)
			outcome <= sample;
		else
			outcome <= match_pkg::NONE;
	end

endmodule

`default_nettype wire

/* src/score_keeper.sv */
/*
 * Score keeping.
 * Per-player scores, rounds played and the match winner,
 * credited on round_end and cleared on match_clear.
 */
`timescale 1ns/1ps
`default_nettype none

module score_keeper #(
	parameter int WIN_SCORE = 3
) (
	input  wire logic                 Clk,
	input  wire logic                 rst_n,
	input  wire logic                 match_clear,
	input  wire logic                 round_end,
	input  wire match_pkg::outcome_e  outcome,
	output match_pkg::score_pair_t    scores,
	output logic [7:0]                rounds,
	output match_pkg::winner_e        winner
);

	localparam match_pkg::score_t WIN_Q = match_pkg::score_t'(WIN_SCORE);

	match_pkg::outcome_e last_outcome;
	match_pkg::winner_e  winner_q;
	match_pkg::score_t   red_next;
	match_pkg::score_t   blue_next;

	// outcome is a one-cycle pulse ahead of round_end, hold it
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			last_outcome <= match_pkg::NONE;
		else if (outcome != match_pkg::NONE)
			last_outcome <= outcome;
	end

	// opponent of the crashed player gets the point
	assign red_next  = scores.red +
		match_pkg::score_t'(last_outcome == match_pkg::BLUE_CRASH);
	assign blue_next = scores.blue +
		match_pkg::score_t'(last_outcome == match_pkg::RED_CRASH);

	// look ahead so the FSM sees the winner during round-over itself
	always_comb
	begin
		winner = winner_q;
		if (winner_q == match_pkg::NO_WINNER && round_end)
		begin
			if (red_next == WIN_Q)
				winner = match_pkg::RED_WINS;
			else if (blue_next == WIN_Q)
				winner = match_pkg::BLUE_WINS;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n || match_clear)
		begin
			scores   <= '0;
			rounds   <= 8'd0;
			winner_q <= match_pkg::NO_WINNER;
		end
		else if (round_end)
		begin
			scores.red  <= red_next;
			scores.blue <= blue_next;
			// draws count as a round too
			rounds      <= rounds + 8'd1;
			winner_q    <= winner;
		end
	end

endmodule

`default_nettype wire

/* src/status_regs.sv */
/*
 * AXI4-Lite slave with the control and status registers.
 * Control writes become start/abort pulses; status, scores and
 * rounds are returned as read data.
 */
`timescale 1ns/1ps
`default_nettype none

module status_regs (
	input  wire logic                     Clk,
	input  wire logic                     rst_n,
	input  wire match_pkg::axil_req_t     axil_req,
	input  wire match_pkg::match_status_t status,
	output match_pkg::axil_rsp_t          axil_rsp,
	output logic                          start_cmd,
	output logic                          abort_cmd
);

	logic        bvalid_q;
	logic        rvalid_q;
	logic [31:0] rdata_q;
	logic        wr_accept;
	logic        rd_accept;
	logic        ctrl_write;
	logic [31:0] rd_word;

	// address and data only taken together, one write in flight
	assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
	assign rd_accept = axil_req.arvalid && !rvalid_q;

	assign ctrl_write = wr_accept && (axil_req.awaddr == match_pkg::REG_CTRL) &&
		axil_req.wstrb[0];

	// abort wins if both bits set
	assign abort_cmd = ctrl_write && axil_req.wdata[1];
	assign start_cmd = ctrl_write && axil_req.wdata[0] && !axil_req.wdata[1];

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			bvalid_q <= 1'b0;
		else if (wr_accept)
			bvalid_q <= 1'b1;
		else if (axil_req.bready)
			bvalid_q <= 1'b0;
	end

	// read data formatting, unmapped offsets read zero
	always_comb
	begin
		rd_word = 32'd0;
		case (axil_req.araddr)
			match_pkg::REG_STATUS:
			begin
				rd_word[2:0] = status.state;
				rd_word[5:4] = status.winner;
			end
			match_pkg::REG_SCORE:
				rd_word[7:0] = status.scores;
			match_pkg::REG_ROUNDS:
				rd_word[7:0] = status.rounds;
			default:
				rd_word = 32'd0;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			rvalid_q <= 1'b0;
		else if (rd_accept)
			rvalid_q <= 1'b1;
		else if (axil_req.rready)
			rvalid_q <= 1'b0;
	end

	always_ff @(posedge Clk)
	begin
		if (rd_accept)
			rdata_q <= rd_word;
	end

	always_comb
	begin
		axil_rsp.awready = wr_accept;
		axil_rsp.wready  = wr_accept;
		axil_rsp.bresp   = match_pkg::AXI_RESP_OKAY;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.arready = !rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = match_pkg::AXI_RESP_OKAY;
		axil_rsp.rvalid  = rvalid_q;
	end

endmodule

`default_nettype wire

/* src/match_top.sv */
/*
 * Top level of the match control.
 * Wires FSM, frame timer, crash detect, scoring and the AXI4-Lite
 * registers, and carries the game parameters down.
 */
`timescale 1ns/1ps
`default_nettype none

module match_top #(
	parameter int FRAME_DIV        = 16,
	parameter int COUNTDOWN_FRAMES = 3,
	parameter int WIN_SCORE        = 3
) (
	input  wire logic                    Clk,
	input  wire logic                    rst_n,
	input  wire match_pkg::axil_req_t    axil_req,
	input  wire match_pkg::head_colors_t head_colors,
	output match_pkg::axil_rsp_t         axil_rsp,
	output logic                         round_reset
);

	match_pkg::game_state_e  state;
	match_pkg::outcome_e     outcome;
	match_pkg::winner_e      winner;
	match_pkg::score_pair_t  scores;
	match_pkg::match_status_t status;
	logic [7:0]              rounds;
	logic                    start_cmd;
	logic                    abort_cmd;
	logic                    frame_tick;
	logic                    countdown_done;
	logic                    countdown_run;
	logic                    match_clear;

	assign status = '{state: state, winner: winner, scores: scores, rounds: rounds};

	round_fsm u_fsm (
		.Clk(Clk), .rst_n(rst_n),
		.start_cmd(start_cmd), .abort_cmd(abort_cmd),
		.countdown_done(countdown_done), .outcome(outcome), .winner(winner),
		.state(state), .countdown_run(countdown_run),
		.match_clear(match_clear), .round_reset(round_reset)
	);

	frame_timer #(.FRAME_DIV(FRAME_DIV), .COUNTDOWN_FRAMES(COUNTDOWN_FRAMES)) u_timer (
		.Clk(Clk), .rst_n(rst_n), .countdown_run(countdown_run),
		.frame_tick(frame_tick), .countdown_done(countdown_done)
	);

	crash_detect u_crash (
		.Clk(Clk), .rst_n(rst_n), .frame_tick(frame_tick),
		.state(state), .head_colors(head_colors), .outcome(outcome)
	);

	// round_end is the same pulse the renderer gets
	score_keeper #(.WIN_SCORE(WIN_SCORE)) u_score (
		.Clk(Clk), .rst_n(rst_n), .match_clear(match_clear),
		.round_end(round_reset), .outcome(outcome),
		.scores(scores), .rounds(rounds), .winner(winner)
	);

	status_regs u_regs (
		.Clk(Clk), .rst_n(rst_n), .axil_req(axil_req), .status(status),
		.axil_rsp(axil_rsp), .start_cmd(start_cmd), .abort_cmd(abort_cmd)
	);

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
/*
 * Testbench clock and reset source.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic Clk,
	output logic rst_n
);

	initial
	begin
		Clk   = 1'b0;
		rst_n = 1'b0;
		// reset held over two rising edges
		repeat (2) @(posedge Clk);
		@(negedge Clk);
		rst_n = 1'b1;
	end

	always #(PERIOD / 2) Clk = ~Clk;

endmodule

`default_nettype wire

/* bench/match_assertions.sv */
/*
 * Concurrent checks on the score keeper: score limit,
 * scores only move on round end or clear, winner held.
 */
`timescale 1ns/1ps
`default_nettype none

module match_assertions #(
	parameter int WIN_SCORE = 3
) (
	input wire logic                   Clk,
	input wire logic                   rst_n,
	input wire logic                   match_clear,
	input wire logic                   round_end,
	input wire match_pkg::score_pair_t scores,
	input wire match_pkg::winner_e     winner
);

	int fail_count = 0;

	score_limit: assert property (@(posedge Clk) disable iff (!rst_n)
		(32'(scores.red) <= WIN_SCORE) && (32'(scores.blue) <= WIN_SCORE))
	else
	begin
		fail_count++;
		$error("score above the winning score");
	end

	// scores frozen between rounds
	score_stable: assert property (@(posedge Clk) disable iff (!rst_n)
		(!round_end && !match_clear) |=> $stable(scores))
	else
	begin
		fail_count++;
		$error("score changed without round end or clear");
	end

	winner_hold: assert property (@(posedge Clk) disable iff (!rst_n)
		(winner != match_pkg::NO_WINNER && !match_clear) |=> (winner == $past(winner)))
	else
	begin
		fail_count++;
		$error("winner changed before match clear");
	end

endmodule

`default_nettype wire

/* bench/match_tb.sv */
/*
 * Directed testbench for the match control.
 * AXI4-Lite tasks, crash stimulus, typed compare tasks,
 * the six directed tests and the result summary.
 */
`timescale 1ns/1ps
`default_nettype none

module match_tb;

	localparam int         FRAME_DIV   = 16;
	localparam int         WIN_SCORE   = 3;
	localparam int         WAIT_LIMIT  = 400;
	localparam logic [7:0] BG_COLOR    = 8'h01;
	localparam logic [7:0] CRASH_COLOR = 8'h3C;

	logic                    Clk;
	logic                    rst_n;
	match_pkg::axil_req_t    axil_req;
	match_pkg::axil_rsp_t    axil_rsp;
	match_pkg::head_colors_t head_colors;
	logic                    round_reset;

	int                     error_count;
	int                     check_count;
	int                     test_count;
	int                     reset_wait;
	logic [31:0]            rng;
	match_pkg::score_pair_t exp_scores;
	logic [7:0]             exp_rounds;

	tb_clock #(.PERIOD(100)) clk_gen (.Clk(Clk), .rst_n(rst_n));

	match_top uut (
		.Clk(Clk), .rst_n(rst_n), .axil_req(axil_req),
		.head_colors(head_colors), .axil_rsp(axil_rsp), .round_reset(round_reset)
	);

	bind score_keeper match_assertions #(.WIN_SCORE(WIN_SCORE)) u_checks (
		.Clk(Clk), .rst_n(rst_n), .match_clear(match_clear),
		.round_end(round_end), .scores(scores), .winner(winner)
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] r;
		r = x ^ (x << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// crashed player's opponent scores, a draw scores nobody
	function automatic match_pkg::score_pair_t credit_round(
		input match_pkg::score_pair_t prev, input match_pkg::outcome_e kind);
		match_pkg::score_pair_t result;
		result = prev;
		if (kind == match_pkg::RED_CRASH)
			result.blue = prev.blue + 4'd1;
		else if (kind == match_pkg::BLUE_CRASH)
			result.red = prev.red + 4'd1;
		return result;
	endfunction

	task automatic note_failure(input string what);
		error_count++;
		$display("%s", what);
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_state(input string name, input match_pkg::game_state_e got,
		input match_pkg::game_state_e exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_winner(input string name, input match_pkg::winner_e got,
		input match_pkg::winner_e exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_scores(input string name, input match_pkg::score_pair_t got,
		input match_pkg::score_pair_t exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		int waited;
		waited = 0;
		@(negedge Clk);
		axil_req.awaddr  = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hF;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b1;
		// nothing pending, so both readies at the very next edge
		@(posedge Clk);
		check_word("awready", 32'(axil_rsp.awready), 32'd1);
		check_word("wready", 32'(axil_rsp.wready), 32'd1);
		@(negedge Clk);
		while (!axil_rsp.bvalid && waited < WAIT_LIMIT)
		begin
			@(negedge Clk);
			waited++;
		end
		if (axil_rsp.bvalid)
		begin
			// valids still up, no second handshake while bvalid waits
			check_word("awready", 32'(axil_rsp.awready), 32'd0);
			check_word("bresp", 32'(axil_rsp.bresp), 32'd0);
		end
		else
			note_failure($sformatf("write to offset %h got no response", addr));
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		int waited;
		waited = 0;
		data = 32'd0;
		@(negedge Clk);
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b1;
		// no read in flight, address taken at the next edge
		@(posedge Clk);
		check_word("arready", 32'(axil_rsp.arready), 32'd1);
		@(negedge Clk);
		while (!axil_rsp.rvalid && waited < WAIT_LIMIT)
		begin
			@(negedge Clk);
			waited++;
		end
		axil_req.arvalid = 1'b0;
		if (axil_rsp.rvalid)
		begin
			data = axil_rsp.rdata;
			check_word("arready", 32'(axil_rsp.arready), 32'd0);
			check_word("rresp", 32'(axil_rsp.rresp), 32'd0);
		end
		else
			note_failure($sformatf("read from offset %h got no data", addr));
	endtask

	task automatic check_status(input match_pkg::game_state_e exp_state,
		input match_pkg::winner_e exp_winner);
		logic [31:0] word;
		axi_read(match_pkg::REG_STATUS, word);
		check_state("status.state", match_pkg::game_state_e'(word[2:0]), exp_state);
		check_winner("status.winner", match_pkg::winner_e'(word[5:4]), exp_winner);
	endtask

	task automatic check_tally();
		logic [31:0] word;
		axi_read(match_pkg::REG_SCORE, word);
		check_scores("score", match_pkg::score_pair_t'(word[7:0]), exp_scores);
		axi_read(match_pkg::REG_ROUNDS, word);
		check_word("rounds", word, {24'd0, exp_rounds});
	endtask

	// polls STATUS over the bus
	task automatic wait_state(input match_pkg::game_state_e target);
		logic [31:0] word;
		int tries;
		tries = 0;
		axi_read(match_pkg::REG_STATUS, word);
		while (word[2:0] != target && tries < WAIT_LIMIT / 4)
		begin
			axi_read(match_pkg::REG_STATUS, word);
			tries++;
		end
		if (word[2:0] != target)
			note_failure($sformatf("state never reached %s", target.name()));
	endtask

	// crash colours stay until the round reset shows up
	task automatic crash(input match_pkg::outcome_e kind);
		int waited;
		waited = 0;
		@(negedge Clk);
		head_colors.red  = (kind == match_pkg::BLUE_CRASH) ? BG_COLOR : CRASH_COLOR;
		head_colors.blue = (kind == match_pkg::RED_CRASH) ? BG_COLOR : CRASH_COLOR;
		while (!round_reset && waited < WAIT_LIMIT)
		begin
			@(negedge Clk);
			waited++;
		end
		head_colors = '{red: BG_COLOR, blue: BG_COLOR};
		if (!round_reset)
			note_failure($sformatf("no round_reset after %s", kind.name()));
		else
		begin
			@(negedge Clk);
			if (round_reset)
				note_failure("round_reset high for more than one cycle");
		end
	endtask

	task automatic play_round(input match_pkg::outcome_e kind);
		crash(kind);
		exp_scores = credit_round(exp_scores, kind);
		exp_rounds = exp_rounds + 8'd1;
		check_tally();
	endtask

	// fixed frame count, no round may end meanwhile
	task automatic hold_colors(input match_pkg::head_colors_t colors, input int cycles);
		int pulses;
		pulses = 0;
		@(negedge Clk);
		head_colors = colors;
		repeat (cycles)
		begin
			@(negedge Clk);
			if (round_reset)
				pulses++;
		end
		head_colors = '{red: BG_COLOR, blue: BG_COLOR};
		check_word("round_reset pulses", 32'(pulses), 32'd0);
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %s finished, errors so far %0d", name, error_count);
	endtask

	task automatic test_reset();
		logic [31:0] word;
		check_status(match_pkg::IDLE, match_pkg::NO_WINNER);
		check_tally();
		axi_read(4'h6, word);
		check_word("unmapped read", word, 32'd0);
		finish_test("reset");
	endtask

	task automatic test_start();
		axi_write(match_pkg::REG_CTRL, 32'h1);
		check_status(match_pkg::COUNTDOWN, match_pkg::NO_WINNER);
		wait_state(match_pkg::PLAY);
		hold_colors('{red: BG_COLOR, blue: BG_COLOR}, 4 * FRAME_DIV);
		check_tally();
		finish_test("start");
	endtask

	task automatic test_single_crashes();
		play_round(match_pkg::BLUE_CRASH);
		play_round(match_pkg::RED_CRASH);
		finish_test("single_crashes");
	endtask

	task automatic test_draw();
		play_round(match_pkg::DRAW);
		finish_test("draw");
	endtask

	task automatic test_full_match();
		int n;
		match_pkg::outcome_e kind;
		match_pkg::winner_e  exp_winner;
		n = 0;
		while (32'(exp_scores.red) < WIN_SCORE && 32'(exp_scores.blue) < WIN_SCORE && n < 40)
		begin
			rng = next_random(rng);
			case (rng % 32'd3)
				32'd0: kind = match_pkg::RED_CRASH;
				32'd1: kind = match_pkg::BLUE_CRASH;
				default: kind = match_pkg::DRAW;
			endcase
			play_round(kind);
			n++;
		end
		exp_winner = (32'(exp_scores.red) == WIN_SCORE) ? match_pkg::RED_WINS :
			match_pkg::BLUE_WINS;
		wait_state(match_pkg::MATCH_OVER);
		check_status(match_pkg::MATCH_OVER, exp_winner);
		hold_colors('{red: CRASH_COLOR, blue: CRASH_COLOR}, 4 * FRAME_DIV);
		check_status(match_pkg::MATCH_OVER, exp_winner);
		check_tally();
		// new match from match-over
		axi_write(match_pkg::REG_CTRL, 32'h1);
		exp_scores = '0;
		exp_rounds = 8'd0;
		check_status(match_pkg::COUNTDOWN, match_pkg::NO_WINNER);
		check_tally();
		finish_test("full_match");
	endtask

	task automatic test_abort();
		wait_state(match_pkg::PLAY);
		play_round(match_pkg::BLUE_CRASH);
		wait_state(match_pkg::PLAY);
		axi_write(match_pkg::REG_CTRL, 32'h2);
		exp_scores = '0;
		exp_rounds = 8'd0;
		check_status(match_pkg::IDLE, match_pkg::NO_WINNER);
		check_tally();
		// SCORE is read only
		axi_write(match_pkg::REG_SCORE, 32'h0000_0077);
		check_tally();
		finish_test("abort");
	endtask

	initial
	begin
		axil_req    = '0;
		head_colors = '{red: BG_COLOR, blue: BG_COLOR};
		error_count = 0;
		check_count = 0;
		test_count  = 0;
		reset_wait  = 0;
		rng         = 32'h405a;
		exp_scores  = '0;
		exp_rounds  = 8'd0;
		@(negedge Clk);
		while (!rst_n && reset_wait < 20)
		begin
			@(negedge Clk);
			reset_wait++;
		end
		if (!rst_n)
			note_failure("reset never released");
		test_reset();
		test_start();
		test_single_crashes();
		test_draw();
		test_full_match();
		test_abort();
		error_count += uut.u_score.u_checks.fail_count;
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
src/match_pkg.sv
src/round_fsm.sv
src/frame_timer.sv
src/crash_detect.sv
src/score_keeper.sv
src/status_regs.sv
src/match_top.sv
bench/tb_clock.sv
bench/match_assertions.sv
bench/match_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the match control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module match_tb -o match_sim

output=$(./obj_dir/match_sim +verilator+error+limit+100 || true)
echo "$output"

if echo "$output" | grep -q "^Testbench passed$"; then
	exit 0
else
	exit 1
fi
